//--- Bender.yml
package:
  name: rv_exec

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_pkg.sv
      - logic/register_file.sv
      - logic/instr_decoder.sv
      - logic/alu.sv
      - logic/exec_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/exec_tb.sv

//--- build.f
+incdir+logic
logic/rv_pkg.sv
logic/register_file.sv
logic/instr_decoder.sv
logic/alu.sv
logic/exec_top.sv
test/exec_tb.sv

//--- logic/alu.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module alu (
	input  rv_pkg::alu_op_t op,
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	output rv_pkg::word_t   y
);
	import rv_pkg::*;

	// Shift amount is the low bits of b only
	logic [`RV_SHAMT_W-1:0] shamt;
	logic                   lt_s;
	logic                   lt_u;
	word_t                  sra_y;

	assign shamt = b[`RV_SHAMT_W-1:0];

	// Signed and unsigned compares share the operands
	assign lt_s = ($signed(a) < $signed(b));
	assign lt_u = (a < b);

	// Arithmetic right shift keeps the sign
	assign sra_y = word_t'($signed(a) >>> shamt);

	always_comb begin
		case (op)
			`RV_ALU_ADD: begin
				y = a + b;
			end
			`RV_ALU_SUB: begin
				y = a - b;
			end
			`RV_ALU_SLL: begin
				y = a << shamt;
			end
			`RV_ALU_SLT: begin
				// Zero extended flag
				y = word_t'(lt_s);
			end
			`RV_ALU_SLTU: begin
				y = word_t'(lt_u);
			end
			`RV_ALU_XOR: begin
				y = a ^ b;
			end
			`RV_ALU_SRL: begin
				y = a >> shamt;
			end
			`RV_ALU_SRA: begin
				y = sra_y;
			end
			`RV_ALU_OR: begin
				y = a | b;
			end
			`RV_ALU_AND: begin
				y = a & b;
			end
			`RV_ALU_PASSB: begin
				// Used by LUI
				y = b;
			end
			default: begin
				// Undefined codes give zero
				y = '0;
			end
		endcase
	end

endmodule

//--- logic/exec_top.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module exec_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  rv_pkg::instr_t    instr,
	output logic              wb_valid,
	output logic              wb_illegal,
	output rv_pkg::reg_addr_t wb_rd,
	output rv_pkg::word_t     wb_data
);
	import rv_pkg::*;

	// Instruction register
	logic      ir_valid;
	instr_t    ir_instr;

	// Decoder outputs
	reg_addr_t dec_rs1;
	reg_addr_t dec_rs2;
	reg_addr_t dec_rd;
	word_t     dec_imm;
	alu_op_t   dec_alu_op;
	logic      dec_use_imm;
	logic      dec_writes_rd;
	logic      dec_illegal;

	// Register file and ALU
	logic      rf_we;
	word_t     rf_rd1;
	word_t     rf_rd2;
	word_t     alu_b;
	word_t     alu_y;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir_valid <= 1'b0;
		end else begin
			ir_valid <= instr_valid;
		end
	end

	// Only capture a real instruction
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ir_instr <= instr;
		end
	end

	instr_decoder u_dec (
		.instr     (ir_instr),
		.rs1       (dec_rs1),
		.rs2       (dec_rs2),
		.rd        (dec_rd),
		.imm       (dec_imm),
		.alu_op    (dec_alu_op),
		.use_imm   (dec_use_imm),
		.writes_rd (dec_writes_rd),
		.illegal   (dec_illegal)
	);

	// x0 filtering is left to the register file
	assign rf_we = ir_valid && dec_writes_rd;

	register_file u_rf (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (rf_we),
		.ra1   (dec_rs1),
		.ra2   (dec_rs2),
		.wa    (dec_rd),
		.wd    (alu_y),
		.rd1   (rf_rd1),
		.rd2   (rf_rd2)
	);

	// Operand B is rs2 or the immediate
	assign alu_b = dec_use_imm ? dec_imm : rf_rd2;

	alu u_alu (
		.op (dec_alu_op),
		.a  (rf_rd1),
		.b  (alu_b),
		.y  (alu_y)
	);

	// Writeback report, same edge as the register file write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid   <= 1'b0;
			wb_illegal <= 1'b0;
		end else begin
			wb_valid   <= ir_valid;
			wb_illegal <= ir_valid && dec_illegal;
		end
	end

	// Illegal ops report zero data
	always_ff @(posedge clk) begin
		if (ir_valid) begin
			wb_rd   <= dec_rd;
			wb_data <= dec_illegal ? '0 : alu_y;
		end
	end

	a_illegal_valid : assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_illegal |-> wb_valid
	) else $error("wb_illegal without wb_valid");

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module instr_decoder (
	input  rv_pkg::instr_t    instr,
	output rv_pkg::reg_addr_t rs1,
	output rv_pkg::reg_addr_t rs2,
	output rv_pkg::reg_addr_t rd,
	output rv_pkg::word_t     imm,
	output rv_pkg::alu_op_t   alu_op,
	output logic              use_imm,
	output logic              writes_rd,
	output logic              illegal
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_u;
	logic       is_reg;
	logic       is_imm;
	logic       is_lui;
	logic       f7_base;
	logic       f7_alt;
	logic       alt_ok;
	logic       shift_f3;
	logic       f7_bad;
	alu_op_t    f3_op;

	// Fixed RV32I field positions
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	// I immediate is sign extended
	// U immediate fills the upper bits
	assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};

	assign is_reg = (opcode == `RV_OP_REG);
	assign is_imm = (opcode == `RV_OP_IMM);
	assign is_lui = (opcode == `RV_OP_LUI);

	assign f7_base  = (funct7 == `RV_F7_BASE);
	assign f7_alt   = (funct7 == `RV_F7_ALT);
	assign shift_f3 = (funct3 == `RV_F3_SLL) || (funct3 == `RV_F3_SRL);

	// Op from funct3 with the alt bit picking SUB or SRA
	// No SUB on OP-IMM where the top bits are immediate
	always_comb begin
		f3_op  = `RV_ALU_ADD;
		alt_ok = 1'b0;
		case (funct3)
			`RV_F3_ADD: begin
				f3_op  = (is_reg && f7_alt) ? `RV_ALU_SUB : `RV_ALU_ADD;
				alt_ok = is_reg;
			end
			`RV_F3_SLL:  f3_op = `RV_ALU_SLL;
			`RV_F3_SLT:  f3_op = `RV_ALU_SLT;
			`RV_F3_SLTU: f3_op = `RV_ALU_SLTU;
			`RV_F3_XOR:  f3_op = `RV_ALU_XOR;
			`RV_F3_SRL: begin
				f3_op  = f7_alt ? `RV_ALU_SRA : `RV_ALU_SRL;
				alt_ok = 1'b1;
			end
			`RV_F3_OR:   f3_op = `RV_ALU_OR;
			default:     f3_op = `RV_ALU_AND;
		endcase
	end

	// funct7 only matters on R-type and on shift immediates
	assign f7_bad = (is_reg || (is_imm && shift_f3)) && !(f7_base || (f7_alt && alt_ok));

	// Supported classes with a good funct7 produce a result
	assign writes_rd = is_lui || ((is_reg || is_imm) && !f7_bad);

	// Unknown opcode or bad funct7
	assign illegal = !(is_reg || is_imm || is_lui) || f7_bad;

	always_comb begin
		alu_op  = f3_op;
		imm     = imm_i;
		use_imm = is_imm;
		if (is_lui) begin
			// LUI routes the U immediate straight through
			alu_op  = `RV_ALU_PASSB;
			imm     = imm_u;
			use_imm = 1'b1;
		end
	end

	// An illegal encoding must never reach the write port
	always_comb begin
		a_no_illegal_write : assert final (!(illegal && writes_rd))
			else $error("illegal instruction requests a write");
	end

endmodule

//--- logic/register_file.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module register_file (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              we,
	input  rv_pkg::reg_addr_t ra1,
	input  rv_pkg::reg_addr_t ra2,
	input  rv_pkg::reg_addr_t wa,
	input  rv_pkg::word_t     wd,
	output rv_pkg::word_t     rd1,
	output rv_pkg::word_t     rd2
);
	import rv_pkg::*;

	// Architectural registers
	word_t regs [0:`RV_REG_CNT-1];

	// Writes to x0 are dropped here
	logic wr_ok;

	assign wr_ok = we && (wa != '0);

	// Async reset puts sp at its boot value
	// Everything else comes up zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_REG_CNT; i++) begin
				if (i == `RV_SP_IDX) begin
					regs[i] <= `RV_SP_RESET;
				end else begin
					regs[i] <= '0;
				end
			end
		end else if (wr_ok) begin
			regs[wa] <= wd;
		end
	end

	// Combinational read ports
	// A write at this edge is visible right after it
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	// x0 never picks up a value, whatever gets written
	a_x0_zero : assert property (
		@(posedge clk) disable iff (!rst_n)
		regs[0] == '0
	) else $error("x0 holds a nonzero value");

endmodule

//--- logic/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and register file geometry
`define RV_XLEN       32
`define RV_ILEN       32
`define RV_REG_CNT    32
`define RV_REG_AW     5
`define RV_SHAMT_W    5

// Stack pointer index and its reset value
`define RV_SP_IDX     2
`define RV_SP_RESET   32'h7fffefe4

// Major opcodes handled by the decoder
`define RV_OP_REG     7'b0110011
`define RV_OP_IMM     7'b0010011
`define RV_OP_LUI     7'b0110111

// funct3 of the integer ops, shared by R and I forms
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SRL     3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct7 variants, alt selects SUB and SRA
`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

// ALU operation codes
`define RV_ALU_OPW    4
`define RV_ALU_ADD    4'd0
`define RV_ALU_SUB    4'd1
`define RV_ALU_SLL    4'd2
`define RV_ALU_SLT    4'd3
`define RV_ALU_SLTU   4'd4
`define RV_ALU_XOR    4'd5
`define RV_ALU_SRL    4'd6
`define RV_ALU_SRA    4'd7
`define RV_ALU_OR     4'd8
`define RV_ALU_AND    4'd9
`define RV_ALU_PASSB  4'd10

`endif

//--- logic/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

	// One architectural data word
	typedef logic [`RV_XLEN-1:0] word_t;

	// Index into the register file, x0 to x31
	typedef logic [`RV_REG_AW-1:0] reg_addr_t;

	// Raw instruction as fetched
	typedef logic [`RV_ILEN-1:0] instr_t;

	// ALU operation select, see RV_ALU_* codes
	typedef logic [`RV_ALU_OPW-1:0] alu_op_t;

endpackage

//--- test/exec_tb.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module exec_tb;
	import rv_pkg::*;

	logic      clk;
	logic      rst_n;
	logic      instr_valid;
	instr_t    instr;
	logic      wb_valid;
	logic      wb_illegal;
	reg_addr_t wb_rd;
	word_t     wb_data;

	// Stimulus table, one slot per entry
	instr_t    instr_q[$];
	reg_addr_t rd_q[$];
	word_t     data_q[$];
	logic      ill_q[$];
	string     name_q[$];

	integer seed;
	int     pass_cnt;
	int     fail_cnt;
	logic   table_ready;

	exec_top dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_illegal  (wb_illegal),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// RV32I encodings
	function automatic instr_t itype_word(input logic [2:0] f3, input reg_addr_t rd,
		input reg_addr_t rs1, input logic [11:0] imm);
		itype_word = {imm, rs1, f3, rd, `RV_OP_IMM};
	endfunction

	function automatic instr_t rtype_word(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		rtype_word = {f7, rs2, rs1, f3, rd, `RV_OP_REG};
	endfunction

	function automatic instr_t lui_word(input reg_addr_t rd, input logic [19:0] imm20);
		lui_word = {imm20, rd, `RV_OP_LUI};
	endfunction

	// I immediate as the ISA sign extends it
	function automatic word_t sext12(input logic [11:0] imm);
		sext12 = {{20{imm[11]}}, imm};
	endfunction

	task automatic add_entry(input instr_t ins, input reg_addr_t rd, input word_t data,
		input logic ill, input string name);
		instr_q.push_back(ins);
		rd_q.push_back(rd);
		data_q.push_back(data);
		ill_q.push_back(ill);
		name_q.push_back(name);
	endtask

	// Register contents noted as the table builds them up
	// x1 = fffffffb, x3 = 64, x13 = 12345000, x9 = fb
	task automatic build_table();
		int          k;
		logic [31:0] rnd;
		logic [11:0] imm;
		// Reset values, sp and a plain register
		add_entry(itype_word(`RV_F3_ADD, 5, 2, 12'h000), 5, 32'h7fffefe4, 1'b0, "reset_sp");
		add_entry(itype_word(`RV_F3_ADD, 6, 7, 12'h000), 6, 32'h0, 1'b0, "reset_zero");
		// I-type group
		add_entry(itype_word(`RV_F3_ADD, 1, 0, 12'hffb), 1, 32'hfffffffb, 1'b0, "addi_neg");
		add_entry(itype_word(`RV_F3_ADD, 3, 0, 12'h064), 3, 32'h64, 1'b0, "addi_pos");
		add_entry(itype_word(`RV_F3_SLT, 4, 1, 12'h001), 4, 32'h1, 1'b0, "slti");
		add_entry(itype_word(`RV_F3_SLTU, 4, 1, 12'h001), 4, 32'h0, 1'b0, "sltiu");
		add_entry(itype_word(`RV_F3_XOR, 7, 3, 12'h0f0), 7, 32'h94, 1'b0, "xori");
		add_entry(itype_word(`RV_F3_OR, 8, 3, 12'h703), 8, 32'h767, 1'b0, "ori");
		add_entry(itype_word(`RV_F3_AND, 9, 1, 12'h0ff), 9, 32'hfb, 1'b0, "andi");
		add_entry(itype_word(`RV_F3_SLL, 10, 3, 12'h004), 10, 32'h640, 1'b0, "slli");
		add_entry(itype_word(`RV_F3_SRL, 11, 1, 12'h004), 11, 32'h0fffffff, 1'b0, "srli");
		// SRAI carries 0100000 in the top immediate bits
		add_entry(itype_word(`RV_F3_SRL, 12, 1, 12'h401), 12, 32'hfffffffd, 1'b0, "srai");
		add_entry(lui_word(13, 20'h12345), 13, 32'h12345000, 1'b0, "lui");
		// R-type group, shift amounts come from x3 low bits = 4
		add_entry(rtype_word(`RV_F7_BASE, 10, 3, `RV_F3_ADD, 14), 14, 32'h6a4, 1'b0, "add");
		add_entry(rtype_word(`RV_F7_ALT, 10, 3, `RV_F3_ADD, 15), 15, 32'hfffffa24, 1'b0, "sub");
		add_entry(rtype_word(`RV_F7_BASE, 3, 3, `RV_F3_SLL, 16), 16, 32'h640, 1'b0, "sll");
		add_entry(rtype_word(`RV_F7_BASE, 3, 1, `RV_F3_SLT, 17), 17, 32'h1, 1'b0, "slt");
		add_entry(rtype_word(`RV_F7_BASE, 3, 1, `RV_F3_SLTU, 18), 18, 32'h0, 1'b0, "sltu");
		add_entry(rtype_word(`RV_F7_BASE, 1, 13, `RV_F3_XOR, 19), 19, 32'hedcbaffb, 1'b0, "xor");
		add_entry(rtype_word(`RV_F7_BASE, 3, 1, `RV_F3_SRL, 20), 20, 32'h0fffffff, 1'b0, "srl");
		add_entry(rtype_word(`RV_F7_ALT, 3, 1, `RV_F3_SRL, 21), 21, 32'hffffffff, 1'b0, "sra");
		add_entry(rtype_word(`RV_F7_BASE, 3, 13, `RV_F3_OR, 22), 22, 32'h12345064, 1'b0, "or");
		add_entry(rtype_word(`RV_F7_BASE, 1, 13, `RV_F3_AND, 23), 23, 32'h12345000, 1'b0, "and");
		// Result read by the very next instruction
		add_entry(itype_word(`RV_F3_ADD, 25, 0, 12'h007), 25, 32'h7, 1'b0, "dep_write");
		add_entry(rtype_word(`RV_F7_BASE, 25, 25, `RV_F3_ADD, 26), 26, 32'he, 1'b0, "dep_read");
		// x0 swallows the write but still reports it
		add_entry(itype_word(`RV_F3_ADD, 0, 0, 12'h005), 0, 32'h5, 1'b0, "x0_write");
		add_entry(rtype_word(`RV_F7_BASE, 0, 0, `RV_F3_ADD, 8), 8, 32'h0, 1'b0, "x0_read");
		// Illegal encodings aimed at x9
		add_entry({20'h0, 5'd9, 7'h7f}, 9, 32'h0, 1'b1, "bad_opcode");
		add_entry(rtype_word(7'b0000001, 3, 3, `RV_F3_ADD, 9), 9, 32'h0, 1'b1, "bad_funct7");
		add_entry(itype_word(`RV_F3_ADD, 27, 9, 12'h000), 27, 32'hfb, 1'b0, "x9_kept");
		// Seeded immediates
		for (k = 0; k < 2; k++) begin
			rnd = $random(seed);
			imm = rnd[11:0];
			add_entry(itype_word(`RV_F3_ADD, 28, 3, imm), 28, 32'h64 + sext12(imm), 1'b0,
				"addi_rand");
			rnd = $random(seed);
			imm = rnd[11:0];
			add_entry(itype_word(`RV_F3_XOR, 29, 13, imm), 29, 32'h12345000 ^ sext12(imm),
				1'b0, "xori_rand");
		end
	endtask

	task automatic check_entry(input int idx);
		int errs;
		errs = 0;
		if (wb_valid !== 1'b1) begin
			$display("[ERROR] %s: wb_valid expected %h got %h", name_q[idx], 1'b1, wb_valid);
			errs++;
		end
		if (wb_illegal !== ill_q[idx]) begin
			$display("[ERROR] %s: wb_illegal expected %h got %h", name_q[idx], ill_q[idx],
				wb_illegal);
			errs++;
		end
		if (wb_rd !== rd_q[idx]) begin
			$display("[ERROR] %s: wb_rd expected %h got %h", name_q[idx], rd_q[idx], wb_rd);
			errs++;
		end
		if (wb_data !== data_q[idx]) begin
			$display("[ERROR] %s: wb_data expected %h got %h", name_q[idx], data_q[idx],
				wb_data);
			errs++;
		end
		if (errs == 0) begin
			pass_cnt++;
			$display("test %0d %s passed", idx, name_q[idx]);
		end else begin
			fail_cnt++;
			$display("test %0d %s failed with %0d mismatches", idx, name_q[idx], errs);
		end
	endtask

	// Watchdog sized from the table
	initial begin
		int limit;
		wait (table_ready);
		limit = (instr_q.size() + 10) * 100;
		#(limit);
		$display("Timeout: run did not finish within %0d ns", limit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int i;
		int n;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		seed        = 67;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		n = instr_q.size();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		// One entry per cycle, result visible two edges after the drive
		for (i = 0; i < n + 2; i++) begin
			@(posedge clk);
			if (i < n) begin
				instr       <= instr_q[i];
				instr_valid <= 1'b1;
			end else begin
				instr_valid <= 1'b0;
			end
			// Sample away from the active edge
			@(negedge clk);
			if (i >= 2) begin
				check_entry(i - 2);
			end
		end
		$display("Summary: %0d tests, %0d passed, %0d failed", n, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
